/* logic/frv_pkg.sv */
/*
 * Shared widths, opcodes, micro-ops and pipeline register layouts for the
 * integer pipeline. RTL files refer to these by scoped name.
 */
package frv_pkg;

localparam int XLEN = 32;                      // Data and address width

typedef logic [XLEN-1:0] xlen_t;               // One machine word
typedef logic [4:0]      reg_addr_t;           // GPR index

localparam xlen_t PC_RESET = 32'h0000_0000;    // First fetch address

// --------------------------------------------------
// Major opcodes of the subset
localparam logic [6:0] OPC_OP     = 7'b0110011; // Reg-reg ALU
localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Reg-imm ALU
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;

typedef enum logic [3:0] {
    UOP_NOP,                                   // Unsupported word, no effect
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_SLT,                                   // Signed compare
    UOP_LUI,
    UOP_JAL,
    UOP_BEQ,
    UOP_BNE
} uop_t;

// --------------------------------------------------
// Two readings of one instruction word
typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
} r_fmt_t;

typedef struct packed {
    logic [11:0] imm;                          // Also top bits of U and J
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;                           // Low bits of B immediate
    logic [6:0]  opcode;
} i_fmt_t;

typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
} instr_u;

// --------------------------------------------------
// Stage registers and side buses
typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     instr;
    reg_addr_t rd;                             // Zero when nothing is written
    xlen_t     opr_a;                          // rs1 value
    xlen_t     opr_b;                          // rs2 value or immediate
    xlen_t     imm;                            // Branch/jump offset or LUI value
    uop_t      uop;
} dec_t;

typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     instr;
    reg_addr_t rd;
    xlen_t     wdata;
    logic      cf;                             // Redirect wanted on retire
    xlen_t     target;
} exe_t;

typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     wdata;
} fwd_t;

typedef struct packed {
    xlen_t     pc;
    xlen_t     instr;
    reg_addr_t rd;
    xlen_t     wdata;
} trace_t;

endpackage

/* logic/frv_gprs.sv */
/*
 * General purpose register file. Two combinational reads, one synchronous
 * write, x0 held at zero.
 */
`timescale 1ns/100ps

module frv_gprs (
    input  logic                g_clk,
    input  logic                arst_n,
    input  frv_pkg::reg_addr_t  rs1_addr,
    input  frv_pkg::reg_addr_t  rs2_addr,
    output frv_pkg::xlen_t      rs1_data,
    output frv_pkg::xlen_t      rs2_data,
    input  logic                rd_wen,
    input  frv_pkg::reg_addr_t  rd_addr,
    input  frv_pkg::xlen_t      rd_wdata
);

frv_pkg::xlen_t regs [32];

always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (rd_wen && rd_addr != '0) begin
        regs[rd_addr] <= rd_wdata;             // x0 keeps its reset zero
    end
end

assign rs1_data = regs[rs1_addr];
assign rs2_data = regs[rs2_addr];

// Writeback must filter x0 before it reaches the file
a_no_x0_write : assert property (@(posedge g_clk) disable iff (!arst_n)
    !(rd_wen && rd_addr == '0));

endmodule

/* logic/frv_fetch.sv */
/*
 * Fetch stage. Issues one instruction-bus request at a time, follows
 * redirects from writeback and holds one fetched word for decode.
 */
`timescale 1ns/100ps

module frv_fetch (
    input  logic             g_clk,
    input  logic             arst_n,
    input  logic             cf_req,           // One-cycle redirect strobe
    input  frv_pkg::xlen_t   cf_target,
    output logic             imem_req,
    output frv_pkg::xlen_t   imem_addr,
    input  logic             imem_gnt,
    input  logic             imem_recv,
    input  frv_pkg::xlen_t   imem_rdata,
    output logic             imem_ack,
    output logic             f_valid,          // Buffer holds a word
    output frv_pkg::xlen_t   f_pc,
    output frv_pkg::instr_u  f_instr
);

logic           req_q;                         // Request on the bus
logic           wait_q;                        // Granted, response not yet taken
logic           drop_q;                        // Outstanding response is stale
logic           cf_pend;                       // Redirect held behind a request
frv_pkg::xlen_t pc_q;                          // Next fetch address
frv_pkg::xlen_t cf_tgt_q;
frv_pkg::xlen_t rsp_pc_q;                      // Address of outstanding fetch

logic           grant;
logic           resp;
logic           redir;
frv_pkg::xlen_t redir_pc;

assign grant     = req_q && imem_gnt;
assign resp      = wait_q && imem_recv;
assign redir     = cf_req || cf_pend;
assign redir_pc  = cf_req ? cf_target : cf_tgt_q;

assign imem_req  = req_q;
assign imem_addr = pc_q;
assign imem_ack  = wait_q;                     // Decode drains the buffer every cycle

always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
        req_q   <= 1'b0;
        wait_q  <= 1'b0;
        drop_q  <= 1'b0;
        cf_pend <= 1'b0;
        pc_q    <= frv_pkg::PC_RESET;
        f_valid <= 1'b0;
    end else begin
        if (grant) begin
            req_q  <= 1'b0;
            wait_q <= 1'b1;
        end else if (resp || !wait_q) begin
            req_q  <= 1'b1;                    // Next request once bus is free
            wait_q <= 1'b0;
        end
        if (redir && (!req_q || grant)) begin
            pc_q <= redir_pc;                  // Address may move now
        end else if (grant) begin
            pc_q <= pc_q + 32'd4;
        end
        cf_pend <= redir && req_q && !grant;   // Wait out the open request
        if (grant) begin
            drop_q <= redir;                   // Granted word is already dead
        end else if (resp) begin
            drop_q <= 1'b0;
        end else if (redir && wait_q) begin
            drop_q <= 1'b1;
        end
        f_valid <= resp && !drop_q && !cf_req;
    end
end

always_ff @(posedge g_clk) begin
    if (cf_req) begin
        cf_tgt_q <= cf_target;
    end
    if (grant) begin
        rsp_pc_q <= pc_q;
    end
    if (resp) begin
        f_pc    <= rsp_pc_q;
        f_instr <= imem_rdata;
    end
end

// Address must hold until the memory takes the request
a_addr_stable : assert property (@(posedge g_clk) disable iff (!arst_n)
    imem_req && !imem_gnt |=> $stable(imem_addr));

endmodule

/* logic/frv_decode.sv */
/*
 * Decode stage. Splits the fetched word, selects micro-op, destination and
 * immediate, and registers the bypassed operands for execute.
 */
`timescale 1ns/100ps

module frv_decode (
    input  logic                g_clk,
    input  logic                arst_n,
    input  logic                flush,         // Kill the word being decoded
    input  logic                f_valid,
    input  frv_pkg::xlen_t      f_pc,
    input  frv_pkg::instr_u     f_instr,
    output frv_pkg::reg_addr_t  rs1_addr,
    output frv_pkg::reg_addr_t  rs2_addr,
    input  frv_pkg::xlen_t      rs1_data,      // Already bypassed
    input  frv_pkg::xlen_t      rs2_data,
    output frv_pkg::dec_t       dec
);

frv_pkg::r_fmt_t rfm;
frv_pkg::i_fmt_t ifm;
frv_pkg::xlen_t  imm_i;
frv_pkg::xlen_t  imm_u;
frv_pkg::xlen_t  imm_j;
frv_pkg::xlen_t  imm_b;
frv_pkg::dec_t   dec_d;

assign rfm      = f_instr.r_fmt;
assign ifm      = f_instr.i_fmt;
assign rs1_addr = rfm.rs1;
assign rs2_addr = rfm.rs2;                     // Junk for I/U/J, never used

// --------------------------------------------------
// Immediates, all built from the I view
assign imm_i = {{20{ifm.imm[11]}}, ifm.imm};
assign imm_u = {ifm.imm, ifm.rs1, ifm.funct3, 12'b0};
assign imm_j = {{12{ifm.imm[11]}}, ifm.rs1, ifm.funct3, ifm.imm[0], ifm.imm[10:1], 1'b0};
assign imm_b = {{20{ifm.imm[11]}}, ifm.rd[0], ifm.imm[10:5], ifm.rd[4:1], 1'b0};

// Shared funct3 map of the reg-reg and reg-imm forms
function automatic frv_pkg::uop_t alu_uop(input logic [2:0] f3);
    case (f3)
        3'b000:  return frv_pkg::UOP_ADD;
        3'b100:  return frv_pkg::UOP_XOR;
        3'b110:  return frv_pkg::UOP_OR;
        3'b111:  return frv_pkg::UOP_AND;
        default: return frv_pkg::UOP_NOP;
    endcase
endfunction

always_comb begin
    dec_d       = '0;
    dec_d.valid = f_valid && !flush;
    dec_d.pc    = f_pc;
    dec_d.instr = f_instr;
    dec_d.rd    = rfm.rd;
    dec_d.opr_a = rs1_data;
    dec_d.opr_b = rs2_data;
    dec_d.imm   = imm_i;
    dec_d.uop   = frv_pkg::UOP_NOP;
    case (rfm.opcode)
        frv_pkg::OPC_OP: begin
            if (rfm.funct7 == 7'h00) begin
                dec_d.uop = (rfm.funct3 == 3'b010) ? frv_pkg::UOP_SLT : alu_uop(rfm.funct3);
            end else if (rfm.funct7 == 7'h20 && rfm.funct3 == 3'b000) begin
                dec_d.uop = frv_pkg::UOP_SUB;
            end
        end
        frv_pkg::OPC_OP_IMM: begin
            dec_d.opr_b = imm_i;               // Immediate replaces rs2
            dec_d.uop   = alu_uop(ifm.funct3);
        end
        frv_pkg::OPC_LUI: begin
            dec_d.imm = imm_u;
            dec_d.uop = frv_pkg::UOP_LUI;
        end
        frv_pkg::OPC_JAL: begin
            dec_d.imm = imm_j;
            dec_d.uop = frv_pkg::UOP_JAL;
        end
        frv_pkg::OPC_BRANCH: begin
            dec_d.imm = imm_b;
            dec_d.rd  = '0;                    // Branches write nothing
            if (ifm.funct3 == 3'b000) begin
                dec_d.uop = frv_pkg::UOP_BEQ;
            end else if (ifm.funct3 == 3'b001) begin
                dec_d.uop = frv_pkg::UOP_BNE;
            end
        end
        default: dec_d.uop = frv_pkg::UOP_NOP;
    endcase
    if (dec_d.uop == frv_pkg::UOP_NOP) begin
        dec_d.rd = '0;                         // Unsupported retires with rd 0
    end
end

always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
        dec <= '0;
    end else begin
        dec <= dec_d;
    end
end

endmodule

/* logic/frv_forward.sv */
/*
 * Operand bypass. Picks the youngest in-flight result for each source
 * register, falling back to the register file.
 */
`timescale 1ns/100ps

module frv_forward (
    input  frv_pkg::reg_addr_t  rs1_addr,
    input  frv_pkg::reg_addr_t  rs2_addr,
    input  frv_pkg::xlen_t      rf_rs1,
    input  frv_pkg::xlen_t      rf_rs2,
    input  frv_pkg::fwd_t       fwd_exe,       // One instruction older
    input  frv_pkg::fwd_t       fwd_wb,        // Two instructions older
    output frv_pkg::xlen_t      rs1_data,
    output frv_pkg::xlen_t      rs2_data
);

function automatic frv_pkg::xlen_t bypass(
    input frv_pkg::reg_addr_t addr,
    input frv_pkg::xlen_t     rf_data
);
    if (addr == '0) begin
        return rf_data;                        // x0 is never forwarded
    end else if (fwd_exe.valid && fwd_exe.rd == addr) begin
        return fwd_exe.wdata;
    end else if (fwd_wb.valid && fwd_wb.rd == addr) begin
        return fwd_wb.wdata;
    end
    return rf_data;
endfunction

assign rs1_data = bypass(rs1_addr, rf_rs1);
assign rs2_data = bypass(rs2_addr, rf_rs2);

endmodule

/* logic/frv_execute.sv */
/*
 * Execute stage. ALU work, branch compare and jump target, registered into
 * the writeback record. The live result also feeds the bypass network.
 */
`timescale 1ns/100ps

module frv_execute (
    input  logic            g_clk,
    input  logic            arst_n,
    input  logic            flush,             // Redirect retiring ahead
    input  frv_pkg::dec_t   dec,
    output frv_pkg::fwd_t   fwd_exe,
    output frv_pkg::exe_t   exe
);

frv_pkg::xlen_t result;
logic           taken;                         // Control flow change

always_comb begin
    result = '0;                               // Branches and NOP write zero
    taken  = 1'b0;
    case (dec.uop)
        frv_pkg::UOP_ADD: result = dec.opr_a + dec.opr_b;
        frv_pkg::UOP_SUB: result = dec.opr_a - dec.opr_b;
        frv_pkg::UOP_AND: result = dec.opr_a & dec.opr_b;
        frv_pkg::UOP_OR:  result = dec.opr_a | dec.opr_b;
        frv_pkg::UOP_XOR: result = dec.opr_a ^ dec.opr_b;
        frv_pkg::UOP_SLT: result = frv_pkg::xlen_t'($signed(dec.opr_a) < $signed(dec.opr_b));
        frv_pkg::UOP_LUI: result = dec.imm;
        frv_pkg::UOP_JAL: begin
            result = dec.pc + 32'd4;           // Link address
            taken  = 1'b1;
        end
        frv_pkg::UOP_BEQ: taken = (dec.opr_a == dec.opr_b);
        frv_pkg::UOP_BNE: taken = (dec.opr_a != dec.opr_b);
        default:          result = '0;
    endcase
end

assign fwd_exe = '{valid: dec.valid, rd: dec.rd, wdata: result};

always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
        exe <= '0;
    end else begin
        exe.valid  <= dec.valid && !flush;
        exe.pc     <= dec.pc;
        exe.instr  <= dec.instr;
        exe.rd     <= dec.rd;
        exe.wdata  <= result;
        exe.cf     <= taken;
        exe.target <= dec.pc + dec.imm;        // PC relative for JAL and B
    end
end

endmodule

/* logic/frv_writeback.sv */
/*
 * Writeback stage. Retires the execute record: register write, redirect
 * strobe to fetch, and a registered trace one edge later.
 */
`timescale 1ns/100ps

module frv_writeback (
    input  logic                g_clk,
    input  logic                arst_n,
    input  frv_pkg::exe_t       exe,
    output frv_pkg::fwd_t       fwd_wb,
    output logic                gpr_wen,
    output frv_pkg::reg_addr_t  gpr_rd,
    output frv_pkg::xlen_t      gpr_wdata,
    output logic                cf_req,        // Also flushes younger stages
    output frv_pkg::xlen_t      cf_target,
    output logic                trs_valid,
    output frv_pkg::trace_t     trs
);

assign fwd_wb    = '{valid: exe.valid, rd: exe.rd, wdata: exe.wdata};

assign gpr_wen   = exe.valid && (exe.rd != '0); // x0 writes stay trace only
assign gpr_rd    = exe.rd;
assign gpr_wdata = exe.wdata;

assign cf_req    = exe.valid && exe.cf;
assign cf_target = exe.target;

always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
        trs_valid <= 1'b0;
        trs       <= '0;
    end else begin
        trs_valid <= exe.valid;
        trs       <= '{pc: exe.pc, instr: exe.instr, rd: exe.rd, wdata: exe.wdata};
    end
end

// Redirect leaves a bubble behind it
a_cf_flush : assert property (@(posedge g_clk) disable iff (!arst_n)
    cf_req |=> !exe.valid);

endmodule

/* logic/frv_core.sv */
/*
 * Top level of the cut-down pipeline. Connects fetch, decode, execute,
 * writeback, the bypass network and the register file.
 */
`timescale 1ns/100ps

module frv_core (
    input  logic                 g_clk,        // Global clock
    input  logic                 arst_n,       // Async reset, active low
    output logic                 imem_req,     // Fetch request
    output frv_pkg::xlen_t       imem_addr,    // Fetch address
    input  logic                 imem_gnt,     // Request accepted
    input  logic                 imem_recv,    // Response present
    input  frv_pkg::xlen_t       imem_rdata,   // Fetched word
    output logic                 imem_ack,     // Response taken
    output logic                 trs_valid,    // Retire strobe
    output frv_pkg::trace_t      trs           // Retire record
);

// --------------------------------------------------
// Inter-stage wiring
logic                 cf_req;                  // Redirect strobe from writeback
frv_pkg::xlen_t       cf_target;               // Redirect destination

logic                 f_valid;                 // Fetch buffer full
frv_pkg::xlen_t       f_pc;
frv_pkg::instr_u      f_instr;

frv_pkg::reg_addr_t   rs1_addr;
frv_pkg::reg_addr_t   rs2_addr;
frv_pkg::xlen_t       rf_rs1;                  // Raw register file reads
frv_pkg::xlen_t       rf_rs2;
frv_pkg::xlen_t       rs1_data;                // After bypass
frv_pkg::xlen_t       rs2_data;

frv_pkg::dec_t        dec;
frv_pkg::exe_t        exe;
frv_pkg::fwd_t        fwd_exe;                 // Result being computed now
frv_pkg::fwd_t        fwd_wb;                  // Result being retired now

logic                 gpr_wen;
frv_pkg::reg_addr_t   gpr_rd;
frv_pkg::xlen_t       gpr_wdata;

// --------------------------------------------------
// Stages
frv_fetch     i_fetch     (.*);

frv_decode    i_decode    (.flush(cf_req), .*); // Redirect kills decode

frv_forward   i_forward   (.*);

frv_execute   i_execute   (.flush(cf_req), .*);

frv_writeback i_writeback (.*);

frv_gprs i_gprs (
    .g_clk    (g_clk    ),
    .arst_n   (arst_n   ),
    .rs1_addr (rs1_addr ),
    .rs2_addr (rs2_addr ),
    .rs1_data (rf_rs1   ),                     // Into bypass, not decode
    .rs2_data (rf_rs2   ),
    .rd_wen   (gpr_wen  ),
    .rd_addr  (gpr_rd   ),
    .rd_wdata (gpr_wdata)
);

endmodule

/* bench/frv_imem_model.sv */
/*
 * Instruction memory model. Grants and answers fetches after random delays
 * of 0 to 3 cycles. The testbench loads the program with load_word.
 */
`timescale 1ns/100ps

module frv_imem_model (
    input  logic            g_clk,
    input  logic            imem_req,
    input  frv_pkg::xlen_t  imem_addr,
    output logic            imem_gnt,
    output logic            imem_recv,
    output frv_pkg::xlen_t  imem_rdata,
    input  logic            imem_ack
);

frv_pkg::xlen_t mem [64];                      // 256 bytes of image
frv_pkg::xlen_t rsp_addr;                      // Address of granted fetch
logic           gnt_seen;                      // Grant at last rising edge
logic           ack_seen;                      // Response taken at last rising edge
logic           busy;                          // Response still owed
int             gnt_wait;
int             rsp_wait;
logic [31:0]    rnd_state;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic int pick_delay();
    rnd_state = xorshift32(rnd_state);
    return int'(rnd_state[1:0]);               // 0 to 3 cycles
endfunction

// Low bits 00 never form a supported opcode
function automatic frv_pkg::xlen_t fill_word(input frv_pkg::xlen_t addr);
    return 32'hbad0_0000 ^ addr;
endfunction

function automatic frv_pkg::xlen_t read_word(input frv_pkg::xlen_t addr);
    return (addr < 32'd256) ? mem[addr[7:2]] : fill_word(addr);
endfunction

task automatic load_word(input int idx, input frv_pkg::xlen_t word);
    mem[idx] = word;
endtask

initial begin
    rnd_state  = 32'd16;                       // Fixed seed
    for (int i = 0; i < 64; i++) begin
        mem[i] = fill_word(32'(i * 4));
    end
    imem_gnt   = 1'b0;
    imem_recv  = 1'b0;
    imem_rdata = '0;
    gnt_seen   = 1'b0;
    ack_seen   = 1'b0;
    busy       = 1'b0;
    rsp_addr   = '0;
    rsp_wait   = 0;
    gnt_wait   = pick_delay();
end

// Handshakes complete on the rising edge
always @(posedge g_clk) begin
    if (imem_req && imem_gnt) begin
        gnt_seen = 1'b1;
        rsp_addr = imem_addr;
    end
    if (imem_recv && imem_ack) begin
        ack_seen = 1'b1;
    end
end

// --------------------------------------------------
// Outputs move on the falling edge
always @(negedge g_clk) begin
    if (ack_seen) begin
        imem_recv = 1'b0;
        busy      = 1'b0;
        ack_seen  = 1'b0;
    end
    if (gnt_seen) begin
        imem_gnt  = 1'b0;
        busy      = 1'b1;
        gnt_seen  = 1'b0;
        rsp_wait  = pick_delay();
        gnt_wait  = pick_delay();              // For the next request
    end
    if (imem_req && !imem_gnt && !busy) begin
        if (gnt_wait == 0) begin
            imem_gnt = 1'b1;
        end else begin
            gnt_wait = gnt_wait - 1;
        end
    end
    if (busy && !imem_recv) begin
        if (rsp_wait == 0) begin
            imem_recv  = 1'b1;
            imem_rdata = read_word(rsp_addr);
        end else begin
            rsp_wait = rsp_wait - 1;
        end
    end
end

endmodule

/* bench/frv_tb.sv */
/*
 * Testbench for the pipeline core. Runs a small program from a table
 * through a memory with random delays and checks every retirement in order.
 */
`timescale 1ns/100ps

module frv_tb;

typedef struct packed {
    frv_pkg::xlen_t     word;                  // Program word at pc = 4 * row
    logic               retires;               // Appears on the trace
    frv_pkg::reg_addr_t rd;
    frv_pkg::xlen_t     wdata;
} row_t;

logic               g_clk;
logic               arst_n;
logic               imem_req;
frv_pkg::xlen_t     imem_addr;
logic               imem_gnt;
logic               imem_recv;
frv_pkg::xlen_t     imem_rdata;
logic               imem_ack;
logic               trs_valid;
frv_pkg::trace_t    trs;

row_t               prog_rows[$];
frv_pkg::trace_t    expect_q[$];               // Retire order
int                 n_expect    = 0;
int                 n_retired   = 0;
logic               table_ready = 1'b0;
logic               all_retired = 1'b0;

frv_core       UUT    (.*);
frv_imem_model i_imem (.*);

initial g_clk = 1'b0;
always #10 g_clk = ~g_clk;                     // 20 ns period

// --------------------------------------------------
// Instruction encoders
function automatic frv_pkg::xlen_t reg_word(
    input logic [6:0] f7,
    input logic [2:0] f3,
    input int         rd,
    input int         rs1,
    input int         rs2
);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), frv_pkg::OPC_OP};
endfunction

function automatic frv_pkg::xlen_t imm_word(
    input logic [2:0] f3,
    input int         rd,
    input int         rs1,
    input int         imm
);
    return {12'(imm), 5'(rs1), f3, 5'(rd), frv_pkg::OPC_OP_IMM};
endfunction

function automatic frv_pkg::xlen_t lui_word(input int rd, input logic [19:0] imm);
    return {imm, 5'(rd), frv_pkg::OPC_LUI};
endfunction

function automatic frv_pkg::xlen_t jal_word(input int rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), frv_pkg::OPC_JAL};
endfunction

function automatic frv_pkg::xlen_t branch_word(
    input logic [2:0] f3,
    input int         rs1,
    input int         rs2,
    input int         off
);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], frv_pkg::OPC_BRANCH};
endfunction

task automatic add_row(input frv_pkg::xlen_t word, input logic retires, input int rd,
                       input frv_pkg::xlen_t wdata);
    row_t r;
    r.word    = word;
    r.retires = retires;
    r.rd      = 5'(rd);
    r.wdata   = wdata;
    prog_rows.push_back(r);
endtask

// --------------------------------------------------
// Program and expected retire values
task automatic build_program();
    add_row(imm_word(3'b000, 1, 0, 5),             1, 1,  32'h0000_0005); // ADDI x1
    add_row(imm_word(3'b000, 2, 1, -3),            1, 2,  32'h0000_0002); // Distance 1
    add_row(reg_word(7'h20, 3'b000, 3, 2, 1),      1, 3,  32'hffff_fffd); // SUB underflow
    add_row(reg_word(7'h00, 3'b010, 4, 3, 1),      1, 4,  32'h0000_0001); // SLT -3 < 5
    add_row(reg_word(7'h00, 3'b010, 5, 1, 3),      1, 5,  32'h0000_0000); // SLT 5 < -3
    add_row(lui_word(6, 20'h12345),                1, 6,  32'h1234_5000);
    add_row(imm_word(3'b110, 6, 6, 'h678),         1, 6,  32'h1234_5678); // ORI
    add_row(imm_word(3'b100, 7, 6, -1),            1, 7,  32'hedcb_a987); // XORI, not
    add_row(reg_word(7'h00, 3'b111, 8, 7, 6),      1, 8,  32'h0000_0000); // AND
    add_row(reg_word(7'h00, 3'b110, 9, 7, 6),      1, 9,  32'hffff_ffff); // OR
    add_row(reg_word(7'h00, 3'b100, 10, 9, 1),     1, 10, 32'hffff_fffa); // XOR
    add_row(imm_word(3'b000, 0, 1, 7),             1, 0,  32'h0000_000c); // Write to x0
    add_row(reg_word(7'h00, 3'b000, 11, 0, 0),     1, 11, 32'h0000_0000); // x0 still zero
    add_row(imm_word(3'b111, 12, 3, 'hf0),         1, 12, 32'h0000_00f0); // ANDI
    add_row(imm_word(3'b001, 12, 1, 2),            1, 0,  32'h0000_0000); // SLLI unsupported
    add_row(reg_word(7'h00, 3'b000, 14, 12, 1),    1, 14, 32'h0000_00f5); // x12 untouched
    add_row(branch_word(3'b001, 1, 1, 8),          1, 0,  32'h0000_0000); // BNE not taken
    add_row(imm_word(3'b000, 15, 0, 'h11),         1, 15, 32'h0000_0011);
    add_row(branch_word(3'b000, 15, 15, 12),       1, 0,  32'h0000_0000); // BEQ to 0x54
    add_row(imm_word(3'b000, 16, 0, 1),            0, 0,  32'h0000_0000); // Flushed
    add_row(imm_word(3'b000, 16, 0, 2),            0, 0,  32'h0000_0000); // Skipped
    add_row(jal_word(17, 12),                      1, 17, 32'h0000_0058); // JAL to 0x60
    add_row(imm_word(3'b000, 18, 0, 3),            0, 0,  32'h0000_0000); // Flushed
    add_row(imm_word(3'b000, 18, 0, 4),            0, 0,  32'h0000_0000); // Skipped
    add_row(reg_word(7'h00, 3'b000, 19, 17, 16),   1, 19, 32'h0000_0058); // Link value
    add_row(reg_word(7'h20, 3'b000, 20, 0, 19),    1, 20, 32'hffff_ffa8);
    add_row(reg_word(7'h00, 3'b100, 21, 20, 19),   1, 21, 32'hffff_fff0);
endtask

task automatic load_image();
    frv_pkg::trace_t t;
    for (int i = 0; i < prog_rows.size(); i++) begin
        i_imem.load_word(i, prog_rows[i].word);
        if (prog_rows[i].retires) begin
            t.pc    = 32'(i * 4);
            t.instr = prog_rows[i].word;
            t.rd    = prog_rows[i].rd;
            t.wdata = prog_rows[i].wdata;
            expect_q.push_back(t);
        end
    end
    n_expect = expect_q.size();
endtask

// --------------------------------------------------
// Compare tasks
task automatic check_word(input string name, input frv_pkg::xlen_t got,
                          input frv_pkg::xlen_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "wrong value on %s", name);
    end
endtask

task automatic check_reg(input string name, input frv_pkg::reg_addr_t got,
                         input frv_pkg::reg_addr_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s is x%0d, expected x%0d", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "wrong register on %s", name);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "wrong level on %s", name);
    end
endtask

task automatic compare_retire();
    frv_pkg::trace_t exp;
    exp = expect_q.pop_front();
    check_word("trs.pc", trs.pc, exp.pc);
    check_word("trs.instr", trs.instr, exp.instr);
    check_reg("trs.rd", trs.rd, exp.rd);
    check_word("trs.wdata", trs.wdata, exp.wdata);
    n_retired = n_retired + 1;
    if (expect_q.size() == 0) begin
        all_retired = 1'b1;
    end
endtask

// Trace is stable at the falling edge
always @(negedge g_clk) begin
    if (arst_n && trs_valid && !all_retired) begin
        compare_retire();
    end
end

initial begin
    arst_n = 1'b0;
    build_program();
    @(negedge g_clk);                          // Model fill is done by now
    load_image();
    table_ready = 1'b1;
    repeat (8) @(negedge g_clk);
    check_bit("imem_req", imem_req, 1'b0);     // Idle bus in reset
    check_bit("imem_ack", imem_ack, 1'b0);
    check_bit("trs_valid", trs_valid, 1'b0);
    arst_n = 1'b1;
    wait (all_retired);
    $display("TEST PASSED");
    $finish;
end

// Watchdog, 40 cycles per expected retirement
initial begin
    wait (table_ready);
    repeat (n_expect * 40 + 8) @(posedge g_clk);
    $display("Timeout: retirement stalled after %0d of %0d entries", n_retired, n_expect);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
end

endmodule

/* filelist.f */
logic/frv_pkg.sv
logic/frv_gprs.sv
logic/frv_fetch.sv
logic/frv_decode.sv
logic/frv_forward.sv
logic/frv_execute.sv
logic/frv_writeback.sv
logic/frv_core.sv
bench/frv_imem_model.sv
bench/frv_tb.sv
